// File: logic/memCtrlPkg.sv
package memCtrlPkg;

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int BYTE_W    = 8;
    localparam int MAX_BYTES = 4;
    // lane index width inside one word
    localparam int IDX_W     = $clog2(MAX_BYTES);

    // access length in bytes
    typedef logic [2:0] accessLen_t;

    localparam accessLen_t LEN_BYTE = 3'd1;
    localparam accessLen_t LEN_HALF = 3'd2;
    localparam accessLen_t LEN_WORD = 3'd4;

    typedef enum logic [1:0] {
        OP_FETCH = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } memOp_t;

    // ram read/write line
    localparam logic MEM_READ  = 1'b0;
    localparam logic MEM_WRITE = 1'b1;

    typedef struct packed {
        logic              store;
        accessLen_t        len;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } dataReq_t;

    typedef struct packed {
        memOp_t            op;
        accessLen_t        len;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } memReq_t;

    typedef struct packed {
        logic              rw;
        logic [ADDR_W-1:0] addr;
        logic [BYTE_W-1:0] wdata;
    } memPort_t;

    // one issued byte, seen again one cycle later
    typedef struct packed {
        logic             valid;
        logic             isRead;
        logic             last;
        logic [IDX_W-1:0] index;
        logic             isFetch;
    } byteTag_t;

endpackage

// File: logic/memArbiter.sv
module memArbiter import memCtrlPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_stall,

    input  logic              i_fetchEn,
    input  logic [ADDR_W-1:0] i_fetchAddr,

    input  logic              i_dataEn,
    input  dataReq_t          i_dataReq,

    input  logic              i_finish,

    output logic              o_busy,
    output memReq_t           o_req
);

    logic    busy;
    logic    accept;
    memReq_t heldReq;
    memReq_t nextReq;

    // new work only from idle, and never in a stall cycle
    assign accept = !busy && !i_stall && (i_dataEn || i_fetchEn);

    // data port wins over fetch
    always_comb begin
        if (i_dataEn) begin
            nextReq.op    = i_dataReq.store ? OP_STORE : OP_LOAD;
            nextReq.len   = i_dataReq.len;
            nextReq.addr  = i_dataReq.addr;
            nextReq.wdata = i_dataReq.wdata;
        end else begin
            nextReq.op    = OP_FETCH;
            nextReq.len   = LEN_WORD;
            nextReq.addr  = i_fetchAddr;
            nextReq.wdata = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (busy) begin
            // finish may land in a stall cycle, release anyway
            if (i_finish) begin
                busy <= 1'b0;
            end
        end else if (accept) begin
            busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            heldReq <= nextReq;
        end
    end

    assign o_busy = busy;
    assign o_req  = heldReq;

endmodule

// File: logic/byteSequencer.sv
module byteSequencer import memCtrlPkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     i_stall,

    // held request from the arbiter
    input  logic     i_busy,
    input  memReq_t  i_req,

    // ram command, driven every cycle
    output memPort_t o_mem,

    // registered tag of the byte issued last cycle
    output byteTag_t o_tag
);

    accessLen_t       count;
    logic [IDX_W-1:0] lane;
    logic             issue;
    logic             lastByte;
    logic             isStore;
    memPort_t         port;
    byteTag_t         tagNext;
    byteTag_t         tagReg;

    assign lane     = count[IDX_W-1:0];
    assign isStore  = (i_req.op == OP_STORE);
    assign lastByte = (count == accessLen_t'(i_req.len - 3'd1));

    // nothing left once count reaches len
    assign issue = i_busy && !i_stall && (count < i_req.len);

    always_comb begin
        port.rw    = MEM_READ;
        port.addr  = '0;
        port.wdata = '0;
        if (issue) begin
            port.rw    = isStore ? MEM_WRITE : MEM_READ;
            port.addr  = i_req.addr + ADDR_W'(count);
            // store byte k comes from bits 8k up
            port.wdata = i_req.wdata[lane*BYTE_W +: BYTE_W];
        end
    end

    always_comb begin
        tagNext.valid   = issue;
        tagNext.isRead  = !isStore;
        tagNext.last    = lastByte;
        tagNext.index   = lane;
        tagNext.isFetch = (i_req.op == OP_FETCH);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (!i_busy) begin
            // back to zero once finish drops busy
            count <= '0;
        end else if (issue) begin
            count <= count + 3'd1;
        end
    end

    // tag lines up with the read byte coming back from the ram
    always_ff @(posedge clk) begin
        if (rst) begin
            tagReg <= '0;
        end else begin
            tagReg <= tagNext;
        end
    end

    assign o_mem = port;
    assign o_tag = tagReg;

endmodule

// File: logic/byteAssembler.sv
module byteAssembler import memCtrlPkg::*; (
    input  logic              clk,
    input  logic              rst,

    // read byte from the ram, one cycle after its address
    input  logic [BYTE_W-1:0] i_memData,
    input  byteTag_t          i_tag,

    output logic              o_finish,

    output logic              o_fetchDone,
    output logic [DATA_W-1:0] o_fetchInst,

    output logic              o_dataDone,
    output logic [DATA_W-1:0] o_dataRdata
);

    logic [MAX_BYTES-1:0][BYTE_W-1:0] lanes;
    logic                             fetchDone;
    logic                             dataDone;
    logic                             finish;
    logic                             endOfReq;

    assign endOfReq = i_tag.valid && i_tag.last;
    assign finish   = fetchDone || dataDone;

    // lanes not written stay zero, which zero-extends short loads
    always_ff @(posedge clk) begin
        if (rst) begin
            lanes <= '0;
        end else if (finish) begin
            lanes <= '0;
        end else if (i_tag.valid && i_tag.isRead) begin
            lanes[i_tag.index] <= i_memData;
        end
    end

    // done goes to whoever owns the last byte
    always_ff @(posedge clk) begin
        if (rst) begin
            fetchDone <= 1'b0;
            dataDone  <= 1'b0;
        end else begin
            fetchDone <= endOfReq && i_tag.isFetch;
            dataDone  <= endOfReq && !i_tag.isFetch;
        end
    end

    assign o_finish    = finish;
    assign o_fetchDone = fetchDone;
    assign o_dataDone  = dataDone;

    // same word serves both ports, qualified by the matching done
    assign o_fetchInst = lanes;
    assign o_dataRdata = lanes;

endmodule

// File: logic/memCtrl.sv
module memCtrl import memCtrlPkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              i_rdy,
    input  logic              i_ioBufferFull,

    // byte-wide ram
    input  logic [BYTE_W-1:0] i_memData,
    output memPort_t          o_mem,

    // instruction fetch port
    input  logic              i_fetchEn,
    input  logic [ADDR_W-1:0] i_fetchAddr,
    output logic              o_fetchDone,
    output logic [DATA_W-1:0] o_fetchInst,

    // load/store port
    input  logic              i_dataEn,
    input  dataReq_t          i_dataReq,
    output logic              o_dataDone,
    output logic [DATA_W-1:0] o_dataRdata
);

    logic     stall;
    logic     busy;
    logic     finish;
    memReq_t  req;
    byteTag_t tag;

    // core not ready or io buffer full
    assign stall = !i_rdy || i_ioBufferFull;

    memArbiter memArbiter_i (
        .clk         (clk),
        .rst         (rst),
        .i_stall     (stall),
        .i_fetchEn   (i_fetchEn),
        .i_fetchAddr (i_fetchAddr),
        .i_dataEn    (i_dataEn),
        .i_dataReq   (i_dataReq),
        .i_finish    (finish),
        .o_busy      (busy),
        .o_req       (req)
    );

    byteSequencer byteSequencer_i (
        .clk     (clk),
        .rst     (rst),
        .i_stall (stall),
        .i_busy  (busy),
        .i_req   (req),
        .o_mem   (o_mem),
        .o_tag   (tag)
    );

    byteAssembler byteAssembler_i (
        .clk         (clk),
        .rst         (rst),
        .i_memData   (i_memData),
        .i_tag       (tag),
        .o_finish    (finish),
        .o_fetchDone (o_fetchDone),
        .o_fetchInst (o_fetchInst),
        .o_dataDone  (o_dataDone),
        .o_dataRdata (o_dataRdata)
    );

endmodule

// File: tests/memCtrl_asserts.sv
module memCtrl_asserts import memCtrlPkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     i_rdy,
    input logic     i_ioBufferFull,
    input memPort_t i_mem,
    input logic     i_fetchDone,
    input logic     i_dataDone
);

    logic stall;

    assign stall = !i_rdy || i_ioBufferFull;

    fetchDoneOneCycle: assert property (@(posedge clk) disable iff (rst)
        i_fetchDone |=> !i_fetchDone)
        else $error("fetch done held longer than one cycle");

    dataDoneOneCycle: assert property (@(posedge clk) disable iff (rst)
        i_dataDone |=> !i_dataDone)
        else $error("data done held longer than one cycle");

    // one owner per finished request
    donesExclusive: assert property (@(posedge clk) disable iff (rst)
        !(i_fetchDone && i_dataDone))
        else $error("fetch and data done in the same cycle");

    noWriteInStall: assert property (@(posedge clk) disable iff (rst)
        stall |-> (i_mem.rw != MEM_WRITE))
        else $error("ram write issued in a stall cycle");

endmodule

bind memCtrl memCtrl_asserts memCtrl_asserts_i (
    .clk            (clk),
    .rst            (rst),
    .i_rdy          (i_rdy),
    .i_ioBufferFull (i_ioBufferFull),
    .i_mem          (o_mem),
    .i_fetchDone    (o_fetchDone),
    .i_dataDone     (o_dataDone)
);

// File: tests/memCtrlTb.sv
module memCtrlTb import memCtrlPkg::*; ();

    localparam int RAM_SIZE   = 256;
    localparam int CLK_HALF   = 10;
    localparam int RESET_CYC  = 4;
    // about 200 requests of up to 6 cycles, doubled for stalls
    localparam int MAX_CYCLES = 5000;

    logic              clk;
    logic              rst;
    logic              rdy;
    logic              ioBufferFull;
    logic [BYTE_W-1:0] memData;
    memPort_t          memCmd;
    logic              fetchEn;
    logic [ADDR_W-1:0] fetchAddr;
    logic              fetchDone;
    logic [DATA_W-1:0] fetchInst;
    logic              dataEn;
    dataReq_t          dataReq;
    logic              dataDone;
    logic [DATA_W-1:0] dataRdata;

    logic [BYTE_W-1:0] ram [RAM_SIZE];
    logic [BYTE_W-1:0] shadow [RAM_SIZE];

    // expected results in issue order
    logic [DATA_W-1:0] expData[$];
    logic              expDataStore[$];
    logic [DATA_W-1:0] expFetch[$];

    int   seed;
    logic stallOn;
    int   errorCount = 0;
    int   checkCount = 0;
    int   cycles;

    memCtrl memCtrl_i (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (rdy),
        .i_ioBufferFull (ioBufferFull),
        .i_memData      (memData),
        .o_mem          (memCmd),
        .i_fetchEn      (fetchEn),
        .i_fetchAddr    (fetchAddr),
        .o_fetchDone    (fetchDone),
        .o_fetchInst    (fetchInst),
        .i_dataEn       (dataEn),
        .i_dataReq      (dataReq),
        .o_dataDone     (dataDone),
        .o_dataRdata    (dataRdata)
    );

    // odd multiplier keeps every address byte distinct
    function automatic logic [7:0] fillByte(input logic [7:0] idx);
        return (idx * 8'd29) ^ 8'h6B;
    endfunction

    function automatic accessLen_t lenFromSel(input logic [1:0] sel);
        case (sel)
            2'd0:    return LEN_BYTE;
            2'd1:    return LEN_HALF;
            default: return LEN_WORD;
        endcase
    endfunction

    // little-endian bytes from the shadow with upper lanes zero
    function automatic logic [31:0] expectedRead(input logic [7:0] addr, input accessLen_t len);
        logic [31:0] word;
        word = '0;
        for (int k = 0; k < MAX_BYTES; k++) begin
            if (k < int'(len)) begin
                word[8*k +: 8] = shadow[addr + 8'(k)];
            end
        end
        return word;
    endfunction

    function automatic void writeShadow(input logic [7:0] addr, input accessLen_t len,
                                        input logic [31:0] wdata);
        for (int k = 0; k < MAX_BYTES; k++) begin
            if (k < int'(len)) begin
                shadow[addr + 8'(k)] = wdata[8*k +: 8];
            end
        end
    endfunction

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %0t %s: got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // one data request, one fetch, or both raised on the same edge
    task automatic runRequest(input logic useData, input logic isStore, input accessLen_t len,
                              input logic [7:0] dAddr, input logic [31:0] wdata,
                              input logic useFetch, input logic [7:0] fAddr);
        dataReq_t req;
        int       edges;
        int       dataAt;
        int       fetchAt;
        logic     dropData;
        logic     dropFetch;
        req.store = isStore;
        req.len   = len;
        req.addr  = {24'h0, dAddr};
        req.wdata = wdata;
        dataAt    = useData ? -1 : 0;
        fetchAt   = useFetch ? -1 : 0;
        // data is served first, so a store lands before the fetch reads
        if (useData) begin
            if (isStore) begin
                writeShadow(dAddr, len, wdata);
                expData.push_back('0);
                expDataStore.push_back(1'b1);
            end else begin
                expData.push_back(expectedRead(dAddr, len));
                expDataStore.push_back(1'b0);
            end
        end
        if (useFetch) begin
            expFetch.push_back(expectedRead(fAddr, LEN_WORD));
        end
        @(posedge clk);
        if (useData) begin
            dataEn  <= 1'b1;
            dataReq <= req;
        end
        if (useFetch) begin
            fetchEn   <= 1'b1;
            fetchAddr <= {24'h0, fAddr};
        end
        edges = 0;
        while (dataAt < 0 || fetchAt < 0) begin
            @(negedge clk);
            dropData  = dataDone;
            dropFetch = fetchDone;
            if (dataDone) begin
                dataAt = edges;
            end
            if (fetchDone) begin
                fetchAt = edges;
            end
            @(posedge clk);
            edges++;
            if (dropData) begin
                dataEn <= 1'b0;
            end
            if (dropFetch) begin
                fetchEn <= 1'b0;
            end
        end
        if (useData && useFetch) begin
            checkValue(32'(dataAt < fetchAt), 32'd1, "data done before fetch done");
        end else if (!stallOn) begin
            // accepted one edge after the raise, done N+1 edges later
            if (useData) begin
                checkValue(dataAt, int'(len) + 2, "data done latency");
            end else begin
                checkValue(fetchAt, MAX_BYTES + 2, "fetch done latency");
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // byte ram with one cycle read latency
    initial begin
        for (int i = 0; i < RAM_SIZE; i++) begin
            ram[8'(i)] <= fillByte(8'(i));
        end
        memData <= '0;
        forever begin
            @(posedge clk);
            if (memCmd.rw == MEM_WRITE) begin
                ram[memCmd.addr[7:0]] <= memCmd.wdata;
            end
            memData <= ram[memCmd.addr[7:0]];
        end
    end

    // random stall cycles drawn at negedge
    initial begin
        logic [31:0] r;
        logic        on;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        forever begin
            @(negedge clk);
            r  = $random(seed);
            on = stallOn;
            @(posedge clk);
            rdy          <= !on || (r[1:0] != 2'b00);
            ioBufferFull <= on && (r[4:2] == 3'b000);
        end
    end

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: no result after %0d cycles, the DUT stopped answering", MAX_CYCLES);
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        $display("=== FAIL ===");
        $finish;
    end

    // compares every done pulse against the queued expectations
    initial begin
        logic        prevData;
        logic        prevFetch;
        logic [31:0] want;
        logic        wantStore;
        prevData  = 1'b0;
        prevFetch = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (dataDone) begin
                    checkValue(32'(prevData), 32'd0, "data done wider than one cycle");
                    checkValue(32'(fetchDone), 32'd0, "both done pulses together");
                    if (expData.size() == 0) begin
                        errorCount++;
                        $display("data done pulse arrived with no load or store outstanding");
                    end else begin
                        want      = expData.pop_front();
                        wantStore = expDataStore.pop_front();
                        if (!wantStore) begin
                            checkValue(dataRdata, want, "load data");
                        end
                    end
                end
                if (fetchDone) begin
                    checkValue(32'(prevFetch), 32'd0, "fetch done wider than one cycle");
                    if (expFetch.size() == 0) begin
                        errorCount++;
                        $display("fetch done pulse arrived with no fetch outstanding");
                    end else begin
                        checkValue(fetchInst, expFetch.pop_front(), "fetched instruction");
                    end
                end
                if (!rdy || ioBufferFull) begin
                    checkValue(32'(memCmd.rw), 32'(MEM_READ), "ram write during stall");
                end
            end
            prevData  = dataDone;
            prevFetch = fetchDone;
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] wdata;
        logic [7:0]  a;
        seed      = 42124;
        rst       = 1'b1;
        stallOn   = 1'b0;
        fetchEn   = 1'b0;
        fetchAddr = '0;
        dataEn    = 1'b0;
        dataReq   = '0;
        for (int i = 0; i < RAM_SIZE; i++) begin
            shadow[8'(i)] = fillByte(8'(i));
        end
        repeat (RESET_CYC) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue(32'(fetchDone), 32'd0, "fetch done after reset");
        checkValue(32'(dataDone), 32'd0, "data done after reset");
        checkValue(32'(memCmd.rw), 32'(MEM_READ), "ram rw after reset");
        @(posedge clk);

        for (int n = 0; n < 8; n++) begin
            r = $random(seed);
            runRequest(1'b0, 1'b0, LEN_BYTE, 8'h00, 32'h0, 1'b1, r[7:0]);
        end

        for (int n = 0; n < 48; n++) begin
            r = $random(seed);
            runRequest(1'b1, 1'b0, lenFromSel(2'(n % 3)), r[7:0], 32'h0, 1'b0, 8'h00);
        end

        // store, then read across it and its neighbors
        for (int n = 0; n < 12; n++) begin
            r     = $random(seed);
            wdata = $random(seed);
            a     = r[7:0];
            runRequest(1'b1, 1'b1, lenFromSel(2'(n % 3)), a, wdata, 1'b0, 8'h00);
            runRequest(1'b1, 1'b0, LEN_WORD, a - 8'd1, 32'h0, 1'b0, 8'h00);
            runRequest(1'b0, 1'b0, LEN_BYTE, 8'h00, 32'h0, 1'b1, a);
        end

        for (int n = 0; n < 8; n++) begin
            r     = $random(seed);
            wdata = $random(seed);
            runRequest(1'b1, r[8], lenFromSel(r[10:9]), r[7:0], wdata, 1'b1, r[23:16]);
        end

        stallOn = 1'b1;
        for (int n = 0; n < 60; n++) begin
            r     = $random(seed);
            wdata = $random(seed);
            runRequest(r[10] | r[11], r[12], lenFromSel(r[9:8]), r[7:0], wdata,
                       !r[10], r[23:16]);
        end
        stallOn = 1'b0;

        repeat (2) @(posedge clk);
        for (int i = 0; i < RAM_SIZE; i++) begin
            checkValue(32'(ram[8'(i)]), 32'(shadow[8'(i)]), $sformatf("ram byte %0d", i));
        end
        checkValue(expData.size(), 32'd0, "data requests left without done");
        checkValue(expFetch.size(), 32'd0, "fetches left without done");

        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: sim.f
logic/memCtrlPkg.sv
logic/memArbiter.sv
logic/byteSequencer.sv
logic/byteAssembler.sv
logic/memCtrl.sv
tests/memCtrl_asserts.sv
tests/memCtrlTb.sv

// File: Makefile
# Verilator flow for the byte-serial memory controller

TOP        ?= memCtrlTb
SIM_F      ?= sim.f
LOG        ?= sim.log
OBJ_DIR    ?= obj_dir
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(SIM_F) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "=== PASS ===" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(SIM_F) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
